//--- logic/disp_settings.svh
`ifndef DISP_SETTINGS_SVH
`define DISP_SETTINGS_SVH

// pixel coordinates and memory-facing widths
`define POS_W 12
`define CELL_IX_W 14
`define CELL_W 32
`define FONT_W 64
`define GLYPH_W 16

// grid sizes, in cells
`define COLS_40 7'd40
`define COLS_50 7'd50
`define COLS_80 7'd80
`define COLS_100 7'd100
`define ROWS_25 7'd25
`define ROWS_50 7'd50

// largest grid is 100 x 50 cells
`define CELLS_MAX 14'd5000

// every pixel spends this many clocks in the pipeline
`define PIPE_DEPTH 5

`endif

//--- logic/dispPkg.sv
`default_nettype none

`include "disp_settings.svh"

package dispPkg;

	typedef logic [`POS_W-1:0] posT; // pixel x or y
	typedef logic [`CELL_IX_W-1:0] cellIxT;
	typedef logic [`CELL_W-1:0] cellWordT;
	typedef logic [`FONT_W-1:0] fontBitsT; // one 8x8 glyph
	typedef logic [`GLYPH_W-1:0] glyphT;
	typedef logic [7:0] chan8T;

	// one colour endpoint, y on top
	typedef struct packed
	{
		logic [5:0] y;
		logic [4:0] v;
		logic [4:0] u;
	} yuv16T;

	// cell word bits 31..30
	typedef enum logic [1:0]
	{
		tagText = 2'd0,
		tagBitmap = 2'd1,
		tagYuv = 2'd2,
		tagColor = 2'd3
	} cellTagT;

	// cell word bits 29..28, other codes decode to black
	typedef enum logic [1:0]
	{
		form6 = 2'd0,
		form9 = 2'd2
	} clrFormT;

endpackage

`default_nettype wire

//--- logic/pixelSlotIf.sv
`default_nettype none
`timescale 1ns/1ps

// per-pixel cell geometry, one entry per clock
interface pixelSlotIf;

	logic [5:0] glyphBit; // bit index into the 8x8 glyph
	logic [3:0] mapBit; // bit index into the 4x4 bitmap
	logic cursorHit;
	logic outside; // pixel lies off the cell grid
	logic [6:0] cellX;
	logic [6:0] cellY;

	modport locator (output glyphBit, mapBit, cursorHit, outside, cellX, cellY);

	modport sampler (input glyphBit, mapBit, outside);

	modport composer (input glyphBit, cursorHit, outside);

endinterface

`default_nettype wire

//--- logic/cellLocator.sv
`default_nettype none
`timescale 1ns/1ps

`include "disp_settings.svh"

module cellLocator
(
	input wire logic clock,
	input wire logic rstN,
	input dispPkg::posT pixPosX,
	input dispPkg::posT pixPosY,
	input wire logic col80,
	input wire logic row50,
	input wire logic horz800,
	input wire logic [7:0] cursorX,
	input wire logic [7:0] cursorY,
	output dispPkg::cellIxT cellIx,
	pixelSlotIf.locator slot
);

	logic [6:0] cellX;
	logic [6:0] cellY;
	logic [6:0] numCols;
	logic [6:0] numRows;
	dispPkg::cellIxT cellIxNext;
	logic outsideNext;
	logic cursorNext;
	logic [2:0] glyphRow;
	logic [2:0] glyphCol;
	logic [1:0] mapRow;
	logic [1:0] mapCol;

	always_comb
	begin
		// 8-pixel cells in 80 col / 50 row modes, 16-pixel otherwise
		cellX = col80 ? pixPosX[9:3] : {1'b0, pixPosX[9:4]};
		cellY = row50 ? pixPosY[9:3] : {1'b0, pixPosY[9:4]};

		if (col80)
			numCols = horz800 ? `COLS_100 : `COLS_80;
		else
			numCols = horz800 ? `COLS_50 : `COLS_40;
		numRows = row50 ? `ROWS_50 : `ROWS_25;

		cellIxNext = {7'd0, cellY} * {7'd0, numCols} + {7'd0, cellX};

		outsideNext = (cellX >= numCols) || (cellY >= numRows) ||
			pixPosX[11] || pixPosY[11];
		cursorNext = ({1'b0, cellX} == cursorX) && ({1'b0, cellY} == cursorY);

		// glyph bit 63 is top left of the cell
		glyphRow = 3'd7 - (row50 ? pixPosY[2:0] : pixPosY[3:1]);
		glyphCol = 3'd7 - (col80 ? pixPosX[2:0] : pixPosX[3:1]);
		mapRow = 2'd3 - (row50 ? pixPosY[2:1] : pixPosY[3:2]);
		mapCol = 2'd3 - (col80 ? pixPosX[2:1] : pixPosX[3:2]);
	end

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			cellIx <= '0;
			slot.glyphBit <= '0;
			slot.mapBit <= '0;
			slot.cursorHit <= 1'b0;
			slot.outside <= 1'b1; // nothing valid yet
			slot.cellX <= '0;
			slot.cellY <= '0;
		end
		else
		begin
			cellIx <= cellIxNext; // goes straight to cell memory
			slot.glyphBit <= {glyphRow, glyphCol};
			slot.mapBit <= {mapRow, mapCol};
			slot.cursorHit <= cursorNext;
			slot.outside <= outsideNext;
			slot.cellX <= cellX;
			slot.cellY <= cellY;
		end
	end

	// in-grid pixels must address a real cell of the largest layout
	assert property (@(posedge clock) disable iff (!rstN)
		!slot.outside |-> (cellIx < `CELLS_MAX) && (slot.cellX < `COLS_100) &&
			(slot.cellY < `ROWS_50));

endmodule

`default_nettype wire

//--- logic/glyphSampler.sv
`default_nettype none
`timescale 1ns/1ps

module glyphSampler
(
	input wire logic clock,
	input wire logic rstN,
	input dispPkg::cellWordT cellData,
	input dispPkg::fontBitsT fontData,
	input wire logic blinkSlow,
	input wire logic blinkFast,
	pixelSlotIf.sampler slot,
	output dispPkg::glyphT fontGlyph,
	output logic patternBit
);

	logic [2:0][5:0] glyphBitD; // slot copies at k+1, k+2, k+3
	logic [2:0][3:0] mapBitD;
	logic outsideD;
	dispPkg::cellTagT tag2;
	dispPkg::cellTagT tag3;
	logic [1:0] blink2; // {slow, fast}
	logic [1:0] blink3;
	logic [15:0] bitmap3;
	logic blinkNow;
	logic patNext;

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			glyphBitD <= '0;
			mapBitD <= '0;
			outsideD <= 1'b1;
			fontGlyph <= '0;
			tag2 <= dispPkg::tagText;
			tag3 <= dispPkg::tagText;
			blink2 <= 2'b00;
			blink3 <= 2'b00;
			patternBit <= 1'b0;
		end
		else
		begin
			glyphBitD <= {glyphBitD[1:0], slot.glyphBit};
			mapBitD <= {mapBitD[1:0], slot.mapBit};
			outsideD <= slot.outside;

			// off-grid pixels read as an empty text cell
			fontGlyph <= outsideD ? '0 : cellData[15:0];
			tag2 <= outsideD ? dispPkg::tagText : dispPkg::cellTagT'(cellData[31:30]);
			if (!outsideD && (cellData[31:30] == 2'b00))
				blink2 <= {cellData[15:14] == 2'b10, cellData[15:14] == 2'b01};
			else
				blink2 <= 2'b00;

			tag3 <= tag2;
			blink3 <= blink2;
			patternBit <= patNext; // lines up with font data of k+3
		end
	end

	always_ff @(posedge clock)
		bitmap3 <= fontGlyph; // bitmap cells carry pixels in the glyph field

	always_comb
	begin
		blinkNow = (blink3[0] && blinkFast) || (blink3[1] && blinkSlow);
		case (tag3)
			dispPkg::tagText: patNext = fontData[glyphBitD[2]] && !blinkNow;
			dispPkg::tagBitmap: patNext = bitmap3[mapBitD[2]];
			default: patNext = 1'b0;
		endcase
	end

	// font memory must never be addressed with an unknown glyph
	assert property (@(posedge clock) disable iff (!rstN)
		$past(rstN) |-> !$isunknown(fontGlyph));

endmodule

`default_nettype wire

//--- logic/endpointColor.sv
`default_nettype none
`timescale 1ns/1ps

module endpointColor
(
	input wire logic clock,
	input wire logic rstN,
	input dispPkg::cellWordT cellData,
	output dispPkg::yuv16T clrFore,
	output dispPkg::yuv16T clrBack,
	output logic cellBlank
);

	logic [11:0] rgbA; // r:g:b, 4 bits each
	logic [11:0] rgbB;
	dispPkg::yuv16T yuvA;
	dispPkg::yuv16T yuvB;
	logic [1:0] blankD;

	// widen one endpoint to 4 bits per channel
	function automatic logic [11:0] widen(input dispPkg::clrFormT form,
		input logic [5:0] c6, input logic [8:0] c9);
		case (form)
			dispPkg::form6: widen = {c6[5:4], c6[5:4], c6[3:2], c6[3:2], c6[1:0], c6[1:0]};
			dispPkg::form9: widen = {c9[8:6], 1'b0, c9[5:3], 1'b0, c9[2:0], 1'b0};
			default: widen = 12'h000;
		endcase
	endfunction

	function automatic dispPkg::yuv16T toYuv(input logic [11:0] rgb);
		logic [3:0] r;
		logic [3:0] g;
		logic [3:0] b;
		r = rgb[11:8];
		g = rgb[7:4];
		b = rgb[3:0];
		toYuv.y = {1'b0, g, 1'b0} + {2'b00, r} + {2'b00, b};
		toYuv.v = 5'd16 + {1'b0, r} - {1'b0, g}; // wraps mod 32
		toYuv.u = 5'd16 + {1'b0, b} - {1'b0, g};
	endfunction

	always_ff @(posedge clock)
	begin
		rgbA <= widen(dispPkg::clrFormT'(cellData[29:28]), cellData[21:16], cellData[18:10]);
		rgbB <= widen(dispPkg::clrFormT'(cellData[29:28]), cellData[27:22], cellData[27:19]);
		yuvA <= toYuv(rgbA);
		yuvB <= toYuv(rgbB);
		clrFore <= yuvA; // aligned with patternBit
		clrBack <= yuvB;
	end

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			blankD <= 2'b11;
			cellBlank <= 1'b1;
		end
		else
		begin
			blankD <= {blankD[0], cellData[31]}; // yuv and colour cells
			cellBlank <= blankD[1];
		end
	end

endmodule

`default_nettype wire

//--- logic/pixelComposer.sv
`default_nettype none
`timescale 1ns/1ps

module pixelComposer
(
	input wire logic clock,
	input wire logic rstN,
	input wire logic patternBit,
	input dispPkg::yuv16T clrFore,
	input dispPkg::yuv16T clrBack,
	input wire logic cellBlank,
	input wire logic blinkSlow,
	pixelSlotIf.composer slot,
	output dispPkg::chan8T pixY,
	output dispPkg::chan8T pixU,
	output dispPkg::chan8T pixV
);

	localparam dispPkg::chan8T blankY = 8'h00;
	localparam dispPkg::chan8T blankUv = 8'h80;

	logic [3:0][2:0] rowD; // glyph row, k+1 .. k+4
	logic [3:0] cursorD;
	logic [3:0] outsideD;
	logic useFore;
	logic blankNow;
	dispPkg::yuv16T clrSel;

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			rowD <= '0;
			cursorD <= '0;
			outsideD <= '1;
		end
		else
		begin
			rowD <= {rowD[2:0], slot.glyphBit[5:3]};
			cursorD <= {cursorD[2:0], slot.cursorHit};
			outsideD <= {outsideD[2:0], slot.outside};
		end
	end

	always_comb
	begin
		// cursor is an underline on glyph row 6, shown while slow blink is on
		useFore = patternBit || (cursorD[3] && blinkSlow && (rowD[3] == 3'd1));
		clrSel = useFore ? clrFore : clrBack;
		blankNow = outsideD[3] || cellBlank;
	end

	always_ff @(posedge clock)
	begin
		if (!rstN || blankNow)
		begin
			pixY <= blankY;
			pixU <= blankUv;
			pixV <= blankUv;
		end
		else
		begin
			pixY <= {clrSel.y, clrSel.y[5:4]}; // replicate top bits
			pixU <= {clrSel.u, clrSel.u[4:2]};
			pixV <= {clrSel.v, clrSel.v[4:2]};
		end
	end

	// pipeline still filling on the first clock out of reset
	assert property (@(posedge clock)
		$rose(rstN) |=> (pixY == blankY) && (pixU == blankUv) && (pixV == blankUv));

endmodule

`default_nettype wire

//--- logic/textModeDisplay.sv
`default_nettype none
`timescale 1ns/1ps

module textModeDisplay
(
	input wire logic clock,
	input wire logic rstN,
	input dispPkg::posT pixPosX,
	input dispPkg::posT pixPosY,
	input wire logic col80,
	input wire logic row50,
	input wire logic horz800,
	input wire logic [7:0] cursorX,
	input wire logic [7:0] cursorY,
	input wire logic blinkSlow,
	input wire logic blinkFast,
	input dispPkg::cellWordT cellData, // word for last cycle's cellIx
	input dispPkg::fontBitsT fontData, // bits for last cycle's fontGlyph
	output dispPkg::cellIxT cellIx,
	output dispPkg::glyphT fontGlyph,
	output dispPkg::chan8T pixY,
	output dispPkg::chan8T pixU,
	output dispPkg::chan8T pixV
);

	pixelSlotIf slot ();

	dispPkg::yuv16T clrFore;
	dispPkg::yuv16T clrBack;
	logic cellBlank;
	logic patternBit;

	cellLocator i_locator
	(
		.clock(clock),
		.rstN(rstN),
		.pixPosX(pixPosX),
		.pixPosY(pixPosY),
		.col80(col80),
		.row50(row50),
		.horz800(horz800),
		.cursorX(cursorX),
		.cursorY(cursorY),
		.cellIx(cellIx),
		.slot(slot.locator)
	);

	// glyph path and colour path run side by side off the same cell word
	glyphSampler i_sampler
	(
		.clock(clock),
		.rstN(rstN),
		.cellData(cellData),
		.fontData(fontData),
		.blinkSlow(blinkSlow),
		.blinkFast(blinkFast),
		.slot(slot.sampler),
		.fontGlyph(fontGlyph),
		.patternBit(patternBit)
	);

	endpointColor i_color
	(
		.clock(clock),
		.rstN(rstN),
		.cellData(cellData),
		.clrFore(clrFore),
		.clrBack(clrBack),
		.cellBlank(cellBlank)
	);

	pixelComposer i_composer
	(
		.clock(clock),
		.rstN(rstN),
		.patternBit(patternBit),
		.clrFore(clrFore),
		.clrBack(clrBack),
		.cellBlank(cellBlank),
		.blinkSlow(blinkSlow),
		.slot(slot.composer),
		.pixY(pixY),
		.pixU(pixU),
		.pixV(pixV)
	);

endmodule

`default_nettype wire

//--- verification/tbClock.sv
`default_nettype none
`timescale 1ns/1ps

module tbClock
#(
	parameter int resetCycles = 10
)
(
	output logic clock,
	output logic rstN
);

	initial
	begin
		clock = 1'b0;
		forever #5 clock = ~clock; // 10 ns period
	end

	initial
	begin
		rstN = 1'b0;
		repeat (resetCycles) @(posedge clock);
		#1 rstN = 1'b1; // same 1 ns skew as the other inputs
	end

endmodule

`default_nettype wire

//--- verification/tbTextMode.sv
`default_nettype none
`timescale 1ns/1ps

`include "disp_settings.svh"

module tbTextMode;

	localparam int ringDepth = 8;
	localparam int pixLag = `PIPE_DEPTH + 1; // applied after edge n, pixel registered at edge n+6
	localparam int drainLimit = 40;
	localparam int cellCount = 16384; // every 14-bit cell index

	typedef struct packed
	{
		dispPkg::cellIxT ix;
		dispPkg::glyphT glyph;
		dispPkg::chan8T y;
		dispPkg::chan8T u;
		dispPkg::chan8T v;
	} expectT;

	logic clock;
	logic rstN;
	dispPkg::posT pixPosX;
	dispPkg::posT pixPosY;
	logic col80;
	logic row50;
	logic horz800;
	logic [7:0] cursorX;
	logic [7:0] cursorY;
	logic blinkSlow;
	logic blinkFast;
	dispPkg::cellWordT cellData = '0;
	dispPkg::fontBitsT fontData = '0;
	dispPkg::cellIxT cellIx;
	dispPkg::glyphT fontGlyph;
	dispPkg::chan8T pixY;
	dispPkg::chan8T pixU;
	dispPkg::chan8T pixV;

	dispPkg::cellWordT cellMem [cellCount];
	expectT expRing [ringDepth];
	int expCycle [ringDepth]; // cycle an entry was issued in
	int cycle = 0;
	int inFlight = 0;
	int errorCount = 0;
	logic [31:0] rngState = 32'd91189;

	tbClock i_clock (.clock(clock), .rstN(rstN));

	textModeDisplay i_dut (.*);

	// both memories answer one clock after the address
	always @(posedge clock)
	begin
		cellData <= cellMem[cellIx];
		fontData <= fontOf(fontGlyph);
	end

	always @(posedge clock)
		cycle <= cycle + 1;

	function automatic logic [31:0] lcgNext();
		rngState = rngState * 32'd1664525 + 32'd1013904223;
		return rngState;
	endfunction

	// every glyph number gives its own pattern
	function automatic dispPkg::fontBitsT fontOf(input dispPkg::glyphT g);
		return {g ^ 16'h5a3c, ~g, g * 16'd40503, {g[7:0], g[15:8]}};
	endfunction

	function automatic dispPkg::yuv16T endpointYuv(input dispPkg::cellWordT w, input bit second);
		dispPkg::yuv16T c;
		int wi;
		int ep;
		int r;
		int g;
		int b;
		wi = int'(w);
		r = 0;
		g = 0;
		b = 0;
		if (w[29:28] == 2'b00)
		begin
			ep = second ? (wi >> 22) & 63 : (wi >> 16) & 63;
			r = ((ep >> 4) & 3) * 5; // two bits repeated
			g = ((ep >> 2) & 3) * 5;
			b = (ep & 3) * 5;
		end
		else if (w[29:28] == 2'b10)
		begin
			ep = second ? (wi >> 19) & 511 : (wi >> 10) & 511;
			r = ((ep >> 6) & 7) * 2; // three bits and a zero
			g = ((ep >> 3) & 7) * 2;
			b = (ep & 7) * 2;
		end
		c.y = 6'(2 * g + r + b);
		c.v = 5'((16 + r - g) & 31);
		c.u = 5'((16 + b - g) & 31);
		return c;
	endfunction

	// top bits repeated below the value to fill 8 bits
	function automatic dispPkg::chan8T expand(input int v, input int bits);
		return dispPkg::chan8T'((v << (8 - bits)) | (v >> (2 * bits - 8)));
	endfunction

	function automatic expectT refPixel(input dispPkg::posT x, input dispPkg::posT y);
		expectT e;
		dispPkg::cellWordT w;
		dispPkg::fontBitsT f;
		dispPkg::yuv16T c;
		int xi;
		int yi;
		int cx;
		int cy;
		int cols;
		int rows;
		int gRow;
		int gCol;
		int bitIx;
		logic hidden;
		logic pat;
		logic blinkOff;
		logic fore;
		xi = int'(x);
		yi = int'(y);
		cx = col80 ? (xi >> 3) & 127 : (xi >> 4) & 63; // 8 or 16 pixels per cell
		cy = row50 ? (yi >> 3) & 127 : (yi >> 4) & 63;
		cols = (col80 ? 80 : 40) * (horz800 ? 5 : 4) / 4;
		rows = row50 ? 50 : 25;
		hidden = cx >= cols || cy >= rows || x[11] || y[11];
		e.ix = dispPkg::cellIxT'(cy * cols + cx);
		w = cellMem[e.ix];
		e.glyph = hidden ? '0 : w[15:0];
		gRow = row50 ? yi & 7 : (yi >> 1) & 7; // pixel row within the glyph
		gCol = col80 ? xi & 7 : (xi >> 1) & 7;
		pat = 1'b0;
		if (w[31:30] == 2'b00)
		begin
			f = fontOf(w[15:0]);
			bitIx = (7 - gRow) * 8 + (7 - gCol);
			blinkOff = (w[15:14] == 2'b01 && blinkFast) || (w[15:14] == 2'b10 && blinkSlow);
			pat = f[bitIx[5:0]] && !blinkOff;
		end
		else if (w[31:30] == 2'b01)
		begin
			// one bitmap pixel spans two glyph pixels each way
			bitIx = (3 - gRow / 2) * 4 + (3 - gCol / 2);
			pat = w[bitIx[3:0]];
		end
		fore = pat || (cx == int'(cursorX) && cy == int'(cursorY) && blinkSlow && gRow == 6);
		if (hidden || w[31])
		begin
			e.y = 8'h00;
			e.u = 8'h80;
			e.v = 8'h80;
		end
		else
		begin
			c = endpointYuv(w, !fore); // endpoint A is the foreground
			e.y = expand(int'(c.y), 6);
			e.u = expand(int'(c.u), 5);
			e.v = expand(int'(c.v), 5);
		end
		return e;
	endfunction

	task automatic reportMismatch(input string name, input logic [31:0] got,
		input logic [31:0] want);
		errorCount++;
		$display("[ERROR] %s got 0x%0h expected 0x%0h at %0t", name, got, want, $time);
		$display("SOME TESTS FAILED");
		$fatal(1, "stopped at first mismatch");
	endtask

	task automatic checkChannel(input string name, input dispPkg::chan8T got,
		input dispPkg::chan8T want);
		if (got !== want)
			reportMismatch(name, 32'(got), 32'(want));
	endtask

	task automatic checkCellIx(input dispPkg::cellIxT got, input dispPkg::cellIxT want);
		if (got !== want)
			reportMismatch("cellIx", 32'(got), 32'(want));
	endtask

	task automatic checkGlyph(input dispPkg::glyphT got, input dispPkg::glyphT want);
		if (got !== want)
			reportMismatch("fontGlyph", 32'(got), 32'(want));
	endtask

	task automatic abortRun(input string why);
		$display("timeout: %s", why);
		$display("SOME TESTS FAILED");
		$fatal(1, "run aborted");
	endtask

	task automatic drivePixel(input dispPkg::posT x, input dispPkg::posT y);
		logic [2:0] at;
		@(posedge clock);
		#1;
		pixPosX = x;
		pixPosY = y;
		at = cycle[2:0];
		expRing[at] = refPixel(x, y);
		expCycle[at] = cycle;
		inFlight++;
	endtask

	task automatic drainPipe();
		int waited;
		waited = 0;
		while (inFlight > 0)
		begin
			@(posedge clock);
			#1;
			waited++;
			if (waited > drainLimit)
				abortRun("pipeline did not drain");
		end
	endtask

	// form bit 28 cleared so only the 6-bit and 9-bit forms remain
	task automatic retag(input logic [1:0] tag);
		for (int i = 0; i < cellCount; i++)
		begin
			cellMem[i][31:30] = tag;
			cellMem[i][28] = 1'b0;
		end
	endtask

	// compare process, sampled mid-cycle while outputs are stable
	always @(negedge clock)
	begin
		logic [2:0] at;
		if (rstN && cycle > pixLag)
		begin
			at = 3'(cycle - 1);
			if (expCycle[at] == cycle - 1)
				checkCellIx(cellIx, expRing[at].ix);
			at = 3'(cycle - 3);
			if (expCycle[at] == cycle - 3)
				checkGlyph(fontGlyph, expRing[at].glyph);
			at = 3'(cycle - pixLag);
			if (expCycle[at] == cycle - pixLag)
			begin
				checkChannel("pixY", pixY, expRing[at].y);
				checkChannel("pixU", pixU, expRing[at].u);
				checkChannel("pixV", pixV, expRing[at].v);
				inFlight--;
			end
		end
	end

	initial
	begin
		logic [31:0] r;
		int waited;
		int size;
		int xi;
		int yi;
		pixPosX = '0;
		pixPosY = '0;
		col80 = 1'b0;
		row50 = 1'b0;
		horz800 = 1'b0;
		cursorX = 8'd200; // off every grid
		cursorY = 8'd200;
		blinkSlow = 1'b0;
		blinkFast = 1'b0;
		for (int i = 0; i < ringDepth; i++)
			expCycle[i] = -100;
		for (int i = 0; i < cellCount; i++)
			cellMem[i] = lcgNext();

		// state while reset is held
		repeat (3) @(posedge clock);
		@(negedge clock);
		checkChannel("pixY", pixY, 8'h00);
		checkChannel("pixU", pixU, 8'h80);
		checkChannel("pixV", pixV, 8'h80);
		checkCellIx(cellIx, '0);
		checkGlyph(fontGlyph, '0);
		waited = 0;
		while (!rstN)
		begin
			@(posedge clock);
			waited++;
			if (waited > 30)
				abortRun("reset was never released");
		end
		#1;

		// text cells in every geometry
		retag(2'b00);
		for (int m = 0; m < 8; m++)
		begin
			col80 = m[0];
			row50 = m[1];
			horz800 = m[2];
			for (int n = 0; n < 150; n++)
			begin
				r = lcgNext();
				drivePixel(dispPkg::posT'(r[25:16]), dispPkg::posT'(r[9:0]));
			end
			drainPipe();
		end

		// bitmap cells, full sweep of three cells at 8 and 16 pixels
		retag(2'b01);
		horz800 = 1'b0;
		for (int m = 0; m < 2; m++)
		begin
			col80 = m[0];
			row50 = m[0];
			size = m[0] ? 8 : 16;
			for (int c = 0; c < 3; c++)
				for (int p = 0; p < size * size; p++)
					drivePixel(dispPkg::posT'(c * 17 * size + p % size),
						dispPkg::posT'(c * 11 * size + p / size));
			drainPipe();
		end

		// fast blink, then slow blink
		retag(2'b00);
		col80 = 1'b1;
		row50 = 1'b0;
		horz800 = 1'b1;
		for (int m = 0; m < 2; m++)
		begin
			blinkFast = !m[0];
			blinkSlow = m[0];
			for (int n = 0; n < 200; n++)
			begin
				r = lcgNext();
				drivePixel(dispPkg::posT'(r[25:16]), dispPkg::posT'(r[9:0]));
			end
			drainPipe();
		end
		blinkFast = 1'b0;

		// cursor on cell (5, 3) of the 40 x 25 grid
		col80 = 1'b0;
		row50 = 1'b0;
		horz800 = 1'b0;
		cursorX = 8'd5;
		cursorY = 8'd3;
		cellMem[125][15:14] = 2'b00; // no blink on the cursor cell
		for (int m = 0; m < 2; m++)
		begin
			blinkSlow = !m[0];
			for (int p = 0; p < 256; p++)
				drivePixel(dispPkg::posT'(80 + p % 16), dispPkg::posT'(48 + p / 16));
			drainPipe();
		end
		cursorX = 8'd200;
		blinkSlow = 1'b0;

		// yuv and colour cells, then pixels off the grid
		for (int i = 0; i < cellCount; i++)
			cellMem[i][31:30] = {1'b1, i[0]};
		for (int n = 0; n < 100; n++)
		begin
			r = lcgNext();
			drivePixel(dispPkg::posT'(int'(r[25:16]) % 640), dispPkg::posT'(int'(r[8:0]) % 400));
		end
		drainPipe();
		retag(2'b00);
		for (int n = 0; n < 200; n++)
		begin
			r = lcgNext();
			xi = int'(r[25:16]) % 640;
			yi = int'(r[8:0]) % 400;
			case (n % 4)
				0: xi = 640 + int'(r[25:16]) % 384;
				1: yi = 400 + int'(r[8:0]) % 112;
				2: xi = xi | 2048; // bit 11 set
				default: yi = yi | 2048;
			endcase
			drivePixel(dispPkg::posT'(xi), dispPkg::posT'(yi));
		end
		drainPipe();

		if (errorCount == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- compile.f
+incdir+logic
logic/dispPkg.sv
logic/pixelSlotIf.sv
logic/cellLocator.sv
logic/glyphSampler.sv
logic/endpointColor.sv
logic/pixelComposer.sv
logic/textModeDisplay.sv
verification/tbClock.sv
verification/tbTextMode.sv

//--- Makefile
# Verilator flow for the text mode display pipeline
TOP ?= tbTextMode
VERILATOR ?= verilator
FLIST ?= compile.f
OBJDIR ?= obj_dir
LOG ?= sim.log
PASS_TEXT ?= ALL TESTS PASSED
VFLAGS ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)
